// File: src/tama_pkg.sv
`default_nettype none

package tama_pkg;

  // --------------------------------------------------
  // Display geometry
  // --------------------------------------------------
  localparam int h_active    = 64;
  localparam int h_total     = 80; // Clocks per line
  localparam int v_active    = 16;
  localparam int v_total     = 20;
  localparam int hsync_start = 68;
  localparam int hsync_len   = 6;
  localparam int vsync_line  = 17;

  localparam int h_cnt_w = $clog2(h_total);
  localparam int v_cnt_w = $clog2(v_total);
  localparam int rgb_w   = 24;

  // --------------------------------------------------
  // Segment memory and divider
  // --------------------------------------------------
  localparam int seg_addr_w = 8;
  localparam int seg_data_w = 4;

  localparam int div_w = 10;
  localparam logic [div_w-1:0] div_reset = 10'd100;

  localparam int debounce_ticks = 4; // Equal slow-tick samples before a new level counts

  // --------------------------------------------------
  // Register map, byte offsets
  // --------------------------------------------------
  localparam int wb_adr_w = 11;

  localparam logic [wb_adr_w-1:0] reg_ctrl = 11'h000;
  localparam logic [wb_adr_w-1:0] reg_fg   = 11'h004;
  localparam logic [wb_adr_w-1:0] reg_bg   = 11'h008;
  localparam logic [wb_adr_w-1:0] reg_div  = 11'h00C;
  localparam logic [wb_adr_w-1:0] reg_keys = 11'h010;

  localparam int seg_base_bit = 10; // Set for segment memory accesses

  localparam logic [rgb_w-1:0] fg_reset = 24'h202020;
  localparam logic [rgb_w-1:0] bg_reset = 24'hC8D0B0;

endpackage

`default_nettype wire

// File: src/lcd_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Display settings from the register block to the scanner
interface lcd_cfg_if;

  logic                        all_on;
  logic                        all_off;
  logic [tama_pkg::rgb_w-1:0]  fg_color;
  logic [tama_pkg::rgb_w-1:0]  bg_color;

  modport ctrl (
    output all_on,
    output all_off,
    output fg_color,
    output bg_color
  );

  modport scan (
    input all_on,
    input all_off,
    input fg_color,
    input bg_color
  );

endinterface

`default_nettype wire

// File: src/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic [tama_pkg::div_w-1:0] div_reload,
  output logic                            tick_slow,
  output logic                            tick_fast
);

  logic [tama_pkg::div_w-1:0] count;
  logic [tama_pkg::div_w-1:0] reload_q; // Reload in use for the current period

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count     <= '0;
      reload_q  <= tama_pkg::div_reset;
      tick_slow <= 1'b0;
      tick_fast <= 1'b0;
    end else begin
      tick_slow <= 1'b0;
      tick_fast <= 1'b0;
      count     <= count - 1'b1;

      if (count == '0) begin
        // New reload value is picked up here only
        count     <= div_reload;
        reload_q  <= div_reload;
        tick_slow <= 1'b1;
        tick_fast <= 1'b1;
      end else if (count == (reload_q >> 1)) begin
        tick_fast <= 1'b1; // Midpoint, fast tick alone
      end
    end
  end

endmodule

`default_nettype wire

// File: src/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       tick_slow,
  input  wire logic       left_button,
  input  wire logic       middle_button,
  input  wire logic       right_button,
  output logic [3:0]      keys
);

  logic [2:0] sync_1;
  logic [2:0] sync_2;
  logic [2:0] pressed; // Accepted level, 1 while held

  // One stability counter per button
  logic [$clog2(tama_pkg::debounce_ticks):0] stable_cnt [3];

  // --------------------------------------------------
  // Synchroniser
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_1 <= 3'b111; // Released
      sync_2 <= 3'b111;
    end else begin
      sync_1 <= {left_button, middle_button, right_button};
      sync_2 <= sync_1;
    end
  end

  // --------------------------------------------------
  // Debounce on the slow tick
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pressed <= '0;
      for (int i = 0; i < 3; i++) begin
        stable_cnt[i] <= '0;
      end
    end else if (tick_slow) begin
      for (int i = 0; i < 3; i++) begin
        if (~sync_2[i] == pressed[i]) begin
          stable_cnt[i] <= '0; // Back to the accepted level
        end else if (stable_cnt[i] == tama_pkg::debounce_ticks - 1) begin
          pressed[i]    <= ~sync_2[i];
          stable_cnt[i] <= '0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign keys = {1'b0, pressed}; // Left, middle, right

endmodule

`default_nettype wire

// File: src/lcd_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_cfg_regs (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            wb_cyc,
  input  wire logic                            wb_stb,
  input  wire logic                            wb_we,
  input  wire logic [tama_pkg::wb_adr_w-1:0]   wb_adr,
  input  wire logic [31:0]                     wb_dat_w,
  output logic      [31:0]                     wb_dat_r,
  output logic                                 wb_ack,
  input  wire logic [3:0]                      keys,
  output logic      [tama_pkg::div_w-1:0]      div_reload,
  output logic      [tama_pkg::seg_addr_w-1:0] seg_a_addr,
  output logic                                 seg_a_we,
  output logic      [tama_pkg::seg_data_w-1:0] seg_a_wdata,
  input  wire logic [tama_pkg::seg_data_w-1:0] seg_a_rdata,
  lcd_cfg_if.ctrl                              cfg
);

  logic                        req;
  logic                        seg_sel;
  logic [1:0]                  ctrl_q;
  logic [tama_pkg::rgb_w-1:0]  fg_q;
  logic [tama_pkg::rgb_w-1:0]  bg_q;
  logic [tama_pkg::div_w-1:0]  div_q;

  assign req     = wb_cyc && wb_stb && !wb_ack; // New access this cycle
  assign seg_sel = wb_adr[tama_pkg::seg_base_bit];

  // Segment memory port A, word addressed
  assign seg_a_addr  = wb_adr[tama_pkg::seg_addr_w+1:2];
  assign seg_a_we    = req && wb_we && seg_sel;
  assign seg_a_wdata = wb_dat_w[tama_pkg::seg_data_w-1:0];

  // --------------------------------------------------
  // Ack and settings registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      ctrl_q <= '0;
      fg_q   <= tama_pkg::fg_reset;
      bg_q   <= tama_pkg::bg_reset;
      div_q  <= tama_pkg::div_reset;
    end else begin
      wb_ack <= req;
      if (req && wb_we && !seg_sel) begin
        case (wb_adr)
          tama_pkg::reg_ctrl: ctrl_q <= wb_dat_w[1:0];
          tama_pkg::reg_fg:   fg_q   <= wb_dat_w[tama_pkg::rgb_w-1:0];
          tama_pkg::reg_bg:   bg_q   <= wb_dat_w[tama_pkg::rgb_w-1:0];
          tama_pkg::reg_div:  div_q  <= wb_dat_w[tama_pkg::div_w-1:0];
          default: ; // Keys and unmapped offsets are read-only
        endcase
      end
    end
  end

  // Read mux, the host holds the address through ack
  always_comb begin
    wb_dat_r = '0;
    if (seg_sel) begin
      wb_dat_r[tama_pkg::seg_data_w-1:0] = seg_a_rdata;
    end else begin
      case (wb_adr)
        tama_pkg::reg_ctrl: wb_dat_r[1:0]                  = ctrl_q;
        tama_pkg::reg_fg:   wb_dat_r[tama_pkg::rgb_w-1:0]  = fg_q;
        tama_pkg::reg_bg:   wb_dat_r[tama_pkg::rgb_w-1:0]  = bg_q;
        tama_pkg::reg_div:  wb_dat_r[tama_pkg::div_w-1:0]  = div_q;
        tama_pkg::reg_keys: wb_dat_r[3:0]                  = keys;
        default:            wb_dat_r                       = '0;
      endcase
    end
  end

  assign div_reload   = div_q;
  assign cfg.all_on   = ctrl_q[0];
  assign cfg.all_off  = ctrl_q[1];
  assign cfg.fg_color = fg_q;
  assign cfg.bg_color = bg_q;

endmodule

`default_nettype wire

// File: src/segment_ram.sv
`timescale 1ns/1ps
`default_nettype none

module segment_ram (
  input  wire logic                            clk,
  input  wire logic [tama_pkg::seg_addr_w-1:0] a_addr,
  input  wire logic                            a_we,
  input  wire logic [tama_pkg::seg_data_w-1:0] a_wdata,
  output logic      [tama_pkg::seg_data_w-1:0] a_rdata,
  input  wire logic [tama_pkg::seg_addr_w-1:0] b_addr,
  output logic      [tama_pkg::seg_data_w-1:0] b_rdata
);

  logic [tama_pkg::seg_data_w-1:0] mem [2**tama_pkg::seg_addr_w];

  // Host port, read returns the old word on a write
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    a_rdata <= mem[a_addr];
  end

  // Scanner port
  always_ff @(posedge clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

`default_nettype wire

// File: src/lcd_scan.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_scan (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  lcd_cfg_if.scan                              cfg,
  output logic      [tama_pkg::seg_addr_w-1:0] seg_addr,
  input  wire logic [tama_pkg::seg_data_w-1:0] seg_data,
  output logic                                 hsync,
  output logic                                 vsync,
  output logic                                 de,
  output logic      [tama_pkg::rgb_w-1:0]      rgb
);

  logic [tama_pkg::h_cnt_w-1:0] h_cnt;
  logic [tama_pkg::v_cnt_w-1:0] v_cnt;

  logic       active;
  logic       hs;
  logic       vs;
  logic       active_d1;
  logic       hs_d1;
  logic       vs_d1;
  logic [1:0] bit_d1;  // Dot within the fetched nibble
  logic       dot;

  // --------------------------------------------------
  // Raster counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == tama_pkg::h_total - 1) begin
      h_cnt <= '0;
      if (v_cnt == tama_pkg::v_total - 1) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Index y*16 + x/4
  assign seg_addr = {v_cnt[3:0], h_cnt[5:2]};

  assign active = (h_cnt < tama_pkg::h_active) && (v_cnt < tama_pkg::v_active);
  assign hs     = (h_cnt >= tama_pkg::hsync_start) &&
                  (h_cnt < tama_pkg::hsync_start + tama_pkg::hsync_len);
  assign vs     = (v_cnt == tama_pkg::vsync_line);

  // --------------------------------------------------
  // Pipeline, stage 1 waits on the memory read
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_d1 <= 1'b0;
      hs_d1     <= 1'b0;
      vs_d1     <= 1'b0;
    end else begin
      active_d1 <= active;
      hs_d1     <= hs;
      vs_d1     <= vs;
    end
  end

  always_ff @(posedge clk) begin
    bit_d1 <= h_cnt[1:0];
  end

  assign dot = seg_data[bit_d1];

  // Stage 2, colour rule and sync outputs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de    <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end else begin
      de    <= active_d1;
      hsync <= hs_d1;
      vsync <= vs_d1;
      if (!active_d1) begin
        rgb <= '0; // Blanking
      end else if (cfg.all_off) begin
        rgb <= cfg.bg_color;
      end else if (cfg.all_on || dot) begin
        rgb <= cfg.fg_color;
      end else begin
        rgb <= cfg.bg_color;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tama_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tama_shell (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          left_button,
  input  wire logic                          middle_button,
  input  wire logic                          right_button,
  input  wire logic                          wb_cyc,
  input  wire logic                          wb_stb,
  input  wire logic                          wb_we,
  input  wire logic [tama_pkg::wb_adr_w-1:0] wb_adr,
  input  wire logic [31:0]                   wb_dat_w,
  output logic      [31:0]                   wb_dat_r,
  output logic                               wb_ack,
  output logic                               tick_fast,
  output logic                               hsync,
  output logic                               vsync,
  output logic                               de,
  output logic      [tama_pkg::rgb_w-1:0]    rgb
);

  logic                            tick_slow;
  logic [3:0]                      keys;
  logic [tama_pkg::div_w-1:0]      div_reload;
  logic [tama_pkg::seg_addr_w-1:0] seg_a_addr;
  logic                            seg_a_we;
  logic [tama_pkg::seg_data_w-1:0] seg_a_wdata;
  logic [tama_pkg::seg_data_w-1:0] seg_a_rdata;
  logic [tama_pkg::seg_addr_w-1:0] seg_b_addr;
  logic [tama_pkg::seg_data_w-1:0] seg_b_rdata;

  lcd_cfg_if cfg_if ();

  // --------------------------------------------------
  // Clock enables and keys
  // --------------------------------------------------
  tick_gen tick_gen_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .div_reload (div_reload),
    .tick_slow  (tick_slow),
    .tick_fast  (tick_fast)
  );

  button_sync button_sync_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .tick_slow     (tick_slow),
    .left_button   (left_button),
    .middle_button (middle_button),
    .right_button  (right_button),
    .keys          (keys)
  );

  // --------------------------------------------------
  // Host access and display
  // --------------------------------------------------
  lcd_cfg_regs lcd_cfg_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .keys        (keys),
    .div_reload  (div_reload),
    .seg_a_addr  (seg_a_addr),
    .seg_a_we    (seg_a_we),
    .seg_a_wdata (seg_a_wdata),
    .seg_a_rdata (seg_a_rdata),
    .cfg         (cfg_if)
  );

  segment_ram segment_ram_i (
    .clk     (clk),
    .a_addr  (seg_a_addr),
    .a_we    (seg_a_we),
    .a_wdata (seg_a_wdata),
    .a_rdata (seg_a_rdata),
    .b_addr  (seg_b_addr),
    .b_rdata (seg_b_rdata)
  );

  lcd_scan lcd_scan_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg_if),
    .seg_addr (seg_b_addr),
    .seg_data (seg_b_rdata),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de),
    .rgb      (rgb)
  );

endmodule

`default_nettype wire

// File: verif/tama_shell_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tama_shell_assertions (
  input wire logic                       clk,
  input wire logic                       rst_n,
  input wire logic                       wb_cyc,
  input wire logic                       wb_stb,
  input wire logic                       wb_ack,
  input wire logic                       hsync,
  input wire logic                       vsync,
  input wire logic                       de,
  input wire logic [tama_pkg::rgb_w-1:0] rgb
);

  // --------------------------------------------------
  // Bus handshake
  // --------------------------------------------------
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack high outside an active bus cycle");

  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles");

  // --------------------------------------------------
  // Video outputs
  // --------------------------------------------------
  blank_black: assert property (@(posedge clk) disable iff (!rst_n)
    !de |-> (rgb == '0))
    else $error("rgb not zero while de is low");

  de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
    de |-> !(hsync || vsync))
    else $error("de high during hsync or vsync");

endmodule

`default_nettype wire

// File: verif/tama_shell_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tama_shell_tb;

  localparam int seg_words    = 2 ** tama_pkg::seg_addr_w;
  localparam int row_words    = tama_pkg::h_active / 4;
  localparam int frame_pixels = tama_pkg::h_active * tama_pkg::v_active;
  localparam int frame_cycles = tama_pkg::h_total * tama_pkg::v_total;
  localparam int n_gaps       = 8;
  localparam int n_patterns   = 6;
  localparam int key_reload   = 7;

  // Run budget in clocks, about four cycles per bus access
  localparam int bus_budget   = (2 * seg_words + 40) * 4;
  localparam int video_budget = 4 * 2 * frame_cycles; // Sync search plus one frame each
  localparam int tick_budget  = 3 * (2 ** tama_pkg::div_w) + (n_gaps + 2) * 61;
  localparam int key_budget   = n_patterns * (tama_pkg::debounce_ticks + 2) * (key_reload + 1);
  localparam int max_cycles   = 16 + bus_budget + video_budget + tick_budget + key_budget + 500;

  logic                          clk;
  logic                          rst_n;
  logic                          left_button;
  logic                          middle_button;
  logic                          right_button;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [tama_pkg::wb_adr_w-1:0] wb_adr;
  logic [31:0]                   wb_dat_w;
  logic [31:0]                   wb_dat_r;
  logic                          wb_ack;
  logic                          tick_fast;
  logic                          hsync;
  logic                          vsync;
  logic                          de;
  logic [tama_pkg::rgb_w-1:0]    rgb;

  logic [31:0]                   rng;
  int unsigned                   cycle_cnt = 0;

  // Reference model of the memory and settings
  logic [tama_pkg::seg_data_w-1:0] model_seg [seg_words];
  logic [1:0]                      model_ctrl;
  logic [tama_pkg::rgb_w-1:0]      model_fg;
  logic [tama_pkg::rgb_w-1:0]      model_bg;
  logic [tama_pkg::div_w-1:0]      model_div;

  tama_shell tama_shell_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .left_button   (left_button),
    .middle_button (middle_button),
    .right_button  (right_button),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .tick_fast     (tick_fast),
    .hsync         (hsync),
    .vsync         (vsync),
    .de            (de),
    .rgb           (rgb)
  );

  bind tama_shell tama_shell_assertions tama_shell_assertions_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .hsync  (hsync),
    .vsync  (vsync),
    .de     (de),
    .rgb    (rgb)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("Run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic logic [tama_pkg::wb_adr_w-1:0] seg_adr(input int idx);
    logic [tama_pkg::wb_adr_w-1:0] a;
    a = '0;
    a[tama_pkg::seg_base_bit] = 1'b1;
    a[tama_pkg::seg_addr_w+1:2] = idx[tama_pkg::seg_addr_w-1:0]; // Word addressed
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic bus_access(input logic we, input logic [tama_pkg::wb_adr_w-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdata = wb_dat_r;
    @(negedge clk); // Held through the edge that sees ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [tama_pkg::wb_adr_w-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [tama_pkg::wb_adr_w-1:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic check_regs();
    logic [31:0] d;
    bus_read(tama_pkg::reg_ctrl, d);
    check_value("wb_dat_r reg_ctrl", d, {30'h0, model_ctrl});
    bus_read(tama_pkg::reg_fg, d);
    check_value("wb_dat_r reg_fg", d, {8'h0, model_fg});
    bus_read(tama_pkg::reg_bg, d);
    check_value("wb_dat_r reg_bg", d, {8'h0, model_bg});
    bus_read(tama_pkg::reg_div, d);
    check_value("wb_dat_r reg_div", d, {22'h0, model_div});
    bus_read(tama_pkg::reg_keys, d);
    check_value("wb_dat_r reg_keys", d, 32'h0); // Buttons released here
  endtask

  task automatic check_frame();
    int                         count;
    int                         pos;
    int                         h_pos;
    int                         x;
    int                         y;
    logic                       dot;
    logic                       exp_hs;
    logic [tama_pkg::rgb_w-1:0] exp;
    count = 0;
    pos   = 0; // First sample after vsync falls is dot 0 of a line
    @(negedge clk);
    while (!vsync) @(negedge clk);
    while (vsync) @(negedge clk);
    while (!vsync) begin
      h_pos  = pos % tama_pkg::h_total;
      exp_hs = (h_pos >= tama_pkg::hsync_start) &&
               (h_pos < tama_pkg::hsync_start + tama_pkg::hsync_len);
      check_value("hsync", hsync, exp_hs);
      if (de && count < frame_pixels) begin
        x   = count % tama_pkg::h_active;
        y   = count / tama_pkg::h_active;
        dot = model_seg[y * row_words + x / 4][x % 4];
        if (model_ctrl[1]) exp = model_bg;
        else if (model_ctrl[0] || dot) exp = model_fg;
        else exp = model_bg;
        check_value("rgb", {8'h0, rgb}, {8'h0, exp});
      end
      if (de) count++;
      pos++;
      @(negedge clk);
    end
    check_value("de pixel count", count, frame_pixels);
    check_value("vsync low cycles", pos, frame_cycles - tama_pkg::h_total); // One line of vsync
  endtask

  task automatic wait_fast_pulse(output int gap);
    gap = 1;
    @(negedge clk);
    while (!tick_fast) begin
      @(negedge clk);
      gap++;
    end
  endtask

  task automatic check_ticks(input int reload);
    int gaps [n_gaps];
    int skip;
    int half;
    int first;
    half = reload >> 1;
    // Old period ends within two pulses of the write
    wait_fast_pulse(skip);
    wait_fast_pulse(skip);
    for (int i = 0; i < n_gaps; i++) wait_fast_pulse(gaps[i]);
    first = (gaps[0] == half) ? half : reload - half + 1;
    // Alternating gaps, so each pair sums to reload + 1
    for (int i = 0; i < n_gaps; i++) begin
      check_value("tick_fast gap", gaps[i], (i % 2 == 0) ? first : reload + 1 - first);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0] d;
    int          order [seg_words];
    int          j;
    int          tmp;
    int          reload;
    logic [2:0]  pattern;

    rng           = 32'd58;
    rst_n         = 1'b0;
    left_button   = 1'b1;
    middle_button = 1'b1;
    right_button  = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    model_ctrl    = '0;
    model_fg      = tama_pkg::fg_reset;
    model_bg      = tama_pkg::bg_reset;
    model_div     = tama_pkg::div_reset;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Register readback, reset values first
    check_regs();
    d = rand32();
    bus_write(tama_pkg::reg_ctrl, d);
    model_ctrl = d[1:0];
    d = rand32();
    bus_write(tama_pkg::reg_fg, d);
    model_fg = d[23:0];
    d = rand32();
    bus_write(tama_pkg::reg_bg, d);
    model_bg = d[23:0];
    d = rand32();
    bus_write(tama_pkg::reg_div, d);
    model_div = d[9:0];
    check_regs();
    bus_write(tama_pkg::reg_keys, rand32()); // Read-only
    check_regs();

    // Segment memory fill, then readback in shuffled order
    for (int i = 0; i < seg_words; i++) begin
      d = rand32();
      bus_write(seg_adr(i), d);
      model_seg[i] = d[3:0];
      order[i] = i;
    end
    for (int i = seg_words - 1; i > 0; i--) begin
      j        = rand32() % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < seg_words; i++) begin
      bus_read(seg_adr(order[i]), d);
      check_value("wb_dat_r segment", d, {28'h0, model_seg[order[i]]});
    end

    // Raster, then all_on, all_off and both
    for (int mode = 0; mode < 4; mode++) begin
      d = rand32();
      bus_write(tama_pkg::reg_fg, d);
      model_fg = d[23:0];
      d = rand32();
      bus_write(tama_pkg::reg_bg, d);
      model_bg = d[23:0];
      bus_write(tama_pkg::reg_ctrl, mode);
      model_ctrl = mode[1:0];
      check_frame();
    end

    reload = 8 + (rand32() % 53);
    bus_write(tama_pkg::reg_div, reload);
    model_div = reload[9:0];
    check_ticks(reload);

    // Buttons with a short slow period
    bus_write(tama_pkg::reg_div, key_reload);
    model_div = tama_pkg::div_w'(key_reload);
    wait_fast_pulse(j);
    wait_fast_pulse(j);
    for (int p = 0; p < n_patterns; p++) begin
      d             = rand32();
      pattern       = d[2:0];
      left_button   = ~pattern[2]; // Active low
      middle_button = ~pattern[1];
      right_button  = ~pattern[0];
      repeat ((tama_pkg::debounce_ticks + 2) * (key_reload + 1)) @(negedge clk);
      bus_read(tama_pkg::reg_keys, d);
      check_value("keys", d, {29'h0, pattern});
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tama_shell.f
src/tama_pkg.sv
src/lcd_cfg_if.sv
src/tick_gen.sv
src/button_sync.sv
src/lcd_cfg_regs.sv
src/segment_ram.sv
src/lcd_scan.sv
src/tama_shell.sv
verif/tama_shell_assertions.sv
verif/tama_shell_tb.sv

// File: Makefile
# Verilator build and run of the tama_shell testbench

VERILATOR ?= verilator
TOP       ?= tama_shell_tb
FILELIST  ?= tama_shell.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
